//--- hw/cpu_pkg.sv
package cpu_pkg;

  localparam int XLen = 32;
  localparam int NumRegs = 32;

  typedef logic [XLen-1:0] word_t;
  typedef logic [31:0] inst_t;
  typedef logic [$clog2(NumRegs)-1:0] regaddr_t;
  typedef logic [2:0] aluop_t;

  // ALU operations
  localparam aluop_t AluAdd = 3'd0;
  localparam aluop_t AluSub = 3'd1;
  localparam aluop_t AluAnd = 3'd2;
  localparam aluop_t AluOr = 3'd3;
  localparam aluop_t AluXor = 3'd4;
  localparam aluop_t AluSlt = 3'd5;
  localparam aluop_t AluPassB = 3'd6;

  // RV32I major opcodes in use
  localparam logic [6:0] OpLoad = 7'b0000011;
  localparam logic [6:0] OpStore = 7'b0100011;
  localparam logic [6:0] OpImm = 7'b0010011;
  localparam logic [6:0] OpReg = 7'b0110011;
  localparam logic [6:0] OpLui = 7'b0110111;
  localparam logic [6:0] OpBranch = 7'b1100011;
  localparam logic [6:0] OpJal = 7'b1101111;

endpackage

//--- hw/cpu_ifs.sv
interface dec_ex_if
  import cpu_pkg::*;
();
  logic valid;
  word_t pc;
  aluop_t aluop;
  word_t opa;
  word_t opb;
  word_t store_data;
  // Zero index means the operand is not taken from a register
  regaddr_t rs1;
  regaddr_t rs2;
  regaddr_t rd;
  logic we;
  logic mem_rd;
  logic mem_wr;
  logic link;

  modport src(
      output valid, pc, aluop, opa, opb, store_data, rs1, rs2, rd, we, mem_rd, mem_wr, link
  );
  modport dst(
      input valid, pc, aluop, opa, opb, store_data, rs1, rs2, rd, we, mem_rd, mem_wr, link
  );
endinterface

interface ex_mem_if
  import cpu_pkg::*;
();
  regaddr_t rd;
  logic we;
  logic mem_rd;
  logic mem_wr;
  // ALU result, also the data address of loads and stores
  word_t result;
  word_t store_data;

  modport src(output rd, we, mem_rd, mem_wr, result, store_data);
  modport dst(input rd, we, mem_rd, mem_wr, result, store_data);
endinterface

//--- hw/fetch.sv
module fetch
  import cpu_pkg::*;
#(
  parameter int InstrAddrWidth = 12
) (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      hold_i,
  input  logic                      stall_i,
  input  logic                      redirect_i,
  input  word_t                     target_i,
  output word_t                     pc_o,
  output logic                      inst_read_o,
  output logic [InstrAddrWidth-1:0] inst_addr_o
);

  word_t pc_q;
  word_t req_pc;
  logic  adv;

  // A redirect goes out in the same cycle so only one slot is lost
  assign req_pc = redirect_i ? target_i : pc_q;
  assign adv = !hold_i && !stall_i;

  // One read every cycle, the address simply holds while frozen
  assign inst_read_o = 1'b1;
  assign inst_addr_o = req_pc[InstrAddrWidth-1:0];

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pc_q <= '0;
      pc_o <= '0;
    end else if (adv) begin
      pc_q <= req_pc + word_t'(4);
      // PC of the word that arrives next cycle
      pc_o <= req_pc;
    end
  end

  assert property (@(posedge clk) disable iff (!rstn) pc_o[1:0] == 2'b00);

endmodule

//--- hw/decode.sv
module decode
  import cpu_pkg::*;
(
  input  logic     clk,
  input  logic     rstn,
  input  logic     hold_i,
  input  word_t    pc_i,
  input  inst_t    inst_i,
  input  word_t    rs1_data_i,
  input  word_t    rs2_data_i,
  output regaddr_t rs1_addr_o,
  output regaddr_t rs2_addr_o,
  output logic     stall_o,
  output logic     redirect_o,
  output word_t    target_o,
  dec_ex_if.src    dx
);

  logic id_valid, fetch_live, held, adv;
  word_t id_pc;
  inst_t id_inst, held_inst;
  regaddr_t rd, prev_rd;
  logic prev_we;
  word_t i_imm, s_imm, b_imm, u_imm, j_imm, imm;
  aluop_t aluop;
  logic use_imm, use_rs1, use_rs2, we, mem_rd, mem_wr, is_branch, is_jal;
  logic ex_hit, mem_hit, taken;

  function automatic aluop_t f3_op(logic [2:0] f3, logic sub);
    aluop_t op;
    case (f3)
      3'b010:  op = AluSlt;
      3'b100:  op = AluXor;
      3'b110:  op = AluOr;
      3'b111:  op = AluAnd;
      default: op = sub ? AluSub : AluAdd;
    endcase
    return op;
  endfunction

  assign adv = !hold_i && !stall_o;

  // IF/ID, with a buffer for the word that arrives while the stage is held
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      id_valid <= 1'b0;
      fetch_live <= 1'b0;
      held <= 1'b0;
    end else if (adv) begin
      id_valid <= fetch_live && !redirect_o;
      fetch_live <= 1'b1;
      held <= 1'b0;
    end else if (!held) begin
      held <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (adv) begin
      id_pc <= pc_i;
      id_inst <= held ? held_inst : inst_i;
    end else if (!held) begin
      held_inst <= inst_i;
    end
  end

  assign rd = id_inst[11:7];
  assign rs1_addr_o = id_inst[19:15];
  assign rs2_addr_o = id_inst[24:20];

  assign i_imm = {{20{id_inst[31]}}, id_inst[31:20]};
  assign s_imm = {{20{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
  assign b_imm = {{20{id_inst[31]}}, id_inst[7], id_inst[30:25], id_inst[11:8], 1'b0};
  assign u_imm = {id_inst[31:12], 12'b0};
  assign j_imm = {{12{id_inst[31]}}, id_inst[19:12], id_inst[20], id_inst[30:21], 1'b0};

  always_comb begin
    aluop = AluAdd;
    imm = i_imm;
    use_imm = 1'b1;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    we = 1'b0;
    mem_rd = 1'b0;
    mem_wr = 1'b0;
    is_branch = 1'b0;
    is_jal = 1'b0;
    case (id_inst[6:0])
      OpReg: begin
        aluop = f3_op(id_inst[14:12], id_inst[30]);
        use_imm = 1'b0;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        we = 1'b1;
      end
      OpImm: begin
        aluop = f3_op(id_inst[14:12], 1'b0);
        use_rs1 = 1'b1;
        we = 1'b1;
      end
      OpLui: begin
        aluop = AluPassB;
        imm = u_imm;
        we = 1'b1;
      end
      OpLoad: begin
        use_rs1 = 1'b1;
        we = 1'b1;
        mem_rd = 1'b1;
      end
      OpStore: begin
        imm = s_imm;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        mem_wr = 1'b1;
      end
      OpBranch: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        is_branch = 1'b1;
      end
      OpJal: begin
        we = 1'b1;
        is_jal = 1'b1;
      end
      default: ;
    endcase
  end

  // Producers still in EX or MEM, never x0
  assign ex_hit = dx.valid && dx.we &&
                  ((use_rs1 && dx.rd == rs1_addr_o) || (use_rs2 && dx.rd == rs2_addr_o));
  assign mem_hit = prev_we &&
                   ((use_rs1 && prev_rd == rs1_addr_o) || (use_rs2 && prev_rd == rs2_addr_o));
  assign stall_o = id_valid && ((ex_hit && (dx.mem_rd || is_branch)) || (mem_hit && is_branch));

  // BNE is funct3 001, BEQ 000
  assign taken = id_valid &&
                 (is_jal || (is_branch && ((rs1_data_i == rs2_data_i) ^ id_inst[12])));
  assign redirect_o = taken && !stall_o;
  assign target_o = id_pc + (is_jal ? j_imm : b_imm);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      dx.valid <= 1'b0;
      dx.we <= 1'b0;
      dx.mem_rd <= 1'b0;
      dx.mem_wr <= 1'b0;
      dx.link <= 1'b0;
      prev_we <= 1'b0;
    end else if (!hold_i) begin
      dx.valid <= id_valid && !stall_o;
      dx.we <= we && rd != '0;
      dx.mem_rd <= mem_rd;
      dx.mem_wr <= mem_wr;
      dx.link <= is_jal;
      // Mirrors the EX/MEM write flag
      prev_we <= dx.valid && dx.we;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold_i) begin
      dx.pc <= id_pc;
      dx.aluop <= aluop;
      dx.opa <= rs1_data_i;
      dx.opb <= use_imm ? imm : rs2_data_i;
      dx.store_data <= rs2_data_i;
      dx.rs1 <= use_rs1 ? rs1_addr_o : '0;
      dx.rs2 <= use_rs2 ? rs2_addr_o : '0;
      dx.rd <= rd;
      prev_rd <= dx.rd;
    end
  end

  // A load-use stall lasts a single cycle
  assert property (@(posedge clk) disable iff (!rstn)
    stall_o && !hold_i && !is_branch |=> !stall_o);

endmodule

//--- hw/execute.sv
module execute
  import cpu_pkg::*;
(
  input  logic     clk,
  input  logic     rstn,
  input  logic     hold_i,
  input  regaddr_t wb_rd_i,
  input  logic     wb_we_i,
  input  word_t    wb_data_i,
  dec_ex_if.dst    dx,
  ex_mem_if.src    xm
);

  word_t op_a, op_b, rs2_val, alu_out, result;

  // EX/MEM wins over WB, a load in EX/MEM has no data yet
  function automatic word_t fwd(regaddr_t rs, word_t base);
    word_t val;
    val = base;
    if (xm.we && !xm.mem_rd && xm.rd == rs) begin
      val = xm.result;
    end else if (wb_we_i && wb_rd_i == rs) begin
      val = wb_data_i;
    end
    return val;
  endfunction

  always_comb begin
    op_a = fwd(dx.rs1, dx.opa);
    // For a store rs2 feeds the store data, operand B stays the offset
    rs2_val = fwd(dx.rs2, dx.mem_wr ? dx.store_data : dx.opb);
    op_b = dx.mem_wr ? dx.opb : rs2_val;
  end

  always_comb begin
    case (dx.aluop)
      AluSub:   alu_out = op_a - op_b;
      AluAnd:   alu_out = op_a & op_b;
      AluOr:    alu_out = op_a | op_b;
      AluXor:   alu_out = op_a ^ op_b;
      AluSlt:   alu_out = {{(XLen - 1) {1'b0}}, $signed(op_a) < $signed(op_b)};
      AluPassB: alu_out = op_b;
      default:  alu_out = op_a + op_b;
    endcase
  end

  // JAL links pc+4
  assign result = dx.link ? dx.pc + word_t'(4) : alu_out;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      xm.we <= 1'b0;
      xm.mem_rd <= 1'b0;
      xm.mem_wr <= 1'b0;
    end else if (!hold_i) begin
      xm.we <= dx.valid && dx.we;
      xm.mem_rd <= dx.valid && dx.mem_rd;
      xm.mem_wr <= dx.valid && dx.mem_wr;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold_i) begin
      xm.rd <= dx.rd;
      xm.result <= result;
      xm.store_data <= rs2_val;
    end
  end

endmodule

//--- hw/mem_wb.sv
module mem_wb
  import cpu_pkg::*;
#(
  parameter int DataAddrWidth = 12
) (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     hold_i,
  input  word_t                    data_in_i,
  output logic                     data_read_o,
  output logic                     data_write_o,
  output logic [DataAddrWidth-1:0] data_write_addr_o,
  output word_t                    data_out_o,
  output regaddr_t                 wb_rd_o,
  output logic                     wb_we_o,
  output word_t                    wb_data_o,
  ex_mem_if.dst                    xm
);

  logic  wb_load, ld_held;
  word_t wb_alu, ld_data;

  assign data_read_o = xm.mem_rd;
  assign data_write_o = xm.mem_wr;
  assign data_write_addr_o = xm.result[DataAddrWidth-1:0];
  assign data_out_o = xm.store_data;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wb_we_o <= 1'b0;
      wb_load <= 1'b0;
    end else if (!hold_i) begin
      wb_we_o <= xm.we;
      wb_load <= xm.mem_rd;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold_i) begin
      wb_rd_o <= xm.rd;
      wb_alu <= xm.result;
    end
  end

  // Keep load data seen in the first frozen cycle
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ld_held <= 1'b0;
    end else begin
      ld_held <= hold_i;
    end
  end

  always_ff @(posedge clk) begin
    if (hold_i && !ld_held) begin
      ld_data <= data_in_i;
    end
  end

  assign wb_data_o = !wb_load ? wb_alu : ld_held ? ld_data : data_in_i;

  assert property (@(posedge clk) disable iff (!rstn) !(data_read_o && data_write_o));

endmodule

//--- hw/regfile.sv
module regfile
  import cpu_pkg::*;
(
  input  logic     clk,
  input  logic     rstn,
  input  logic     we_i,
  input  regaddr_t waddr_i,
  input  word_t    wdata_i,
  input  regaddr_t raddr1_i,
  input  regaddr_t raddr2_i,
  output word_t    rdata1_o,
  output word_t    rdata2_o
);

  // x0 has no storage
  word_t regs[1:NumRegs-1];

  function automatic word_t read_port(regaddr_t addr);
    word_t val;
    if (addr == '0) begin
      val = '0;
    end else if (we_i && waddr_i == addr) begin
      val = wdata_i;
    end else begin
      val = regs[addr];
    end
    return val;
  endfunction

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 1; i < NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  always_comb begin
    rdata1_o = read_port(raddr1_i);
    rdata2_o = read_port(raddr2_i);
  end

endmodule

//--- hw/cpu.sv
module cpu
  import cpu_pkg::*;
#(
  parameter int InstrAddrWidth = 12,
  parameter int DataAddrWidth = 12
) (
  input  logic                      clk,
  input  logic                      rstn,
  // Instruction port
  input  inst_t                     inst_in_i,
  output logic                      inst_read_o,
  output logic [InstrAddrWidth-1:0] inst_addr_o,
  // Data port
  input  word_t                     data_in_i,
  output logic                      data_read_o,
  output logic                      data_write_o,
  output logic [ DataAddrWidth-1:0] data_write_addr_o,
  output word_t                     data_out_o,
  // Stall requests from the memories
  input  logic                      stallreq_from_imem,
  input  logic                      stallreq_from_dmem
);

  logic hold, stall, redirect;
  word_t fetch_pc, target;
  regaddr_t rs1_addr, rs2_addr, wb_rd;
  word_t rs1_data, rs2_data, wb_data;
  logic wb_we;

  dec_ex_if dx ();
  ex_mem_if xm ();

  // Either memory freezes the whole pipeline
  assign hold = stallreq_from_imem | stallreq_from_dmem;

  fetch #(
    .InstrAddrWidth(InstrAddrWidth)
  ) u_fetch (
    .clk        (clk),
    .rstn       (rstn),
    .hold_i     (hold),
    .stall_i    (stall),
    .redirect_i (redirect),
    .target_i   (target),
    .pc_o       (fetch_pc),
    .inst_read_o(inst_read_o),
    .inst_addr_o(inst_addr_o)
  );

  decode u_decode (
    .clk       (clk),
    .rstn      (rstn),
    .hold_i    (hold),
    .pc_i      (fetch_pc),
    .inst_i    (inst_in_i),
    .rs1_data_i(rs1_data),
    .rs2_data_i(rs2_data),
    .rs1_addr_o(rs1_addr),
    .rs2_addr_o(rs2_addr),
    .stall_o   (stall),
    .redirect_o(redirect),
    .target_o  (target),
    .dx        (dx.src)
  );

  execute u_execute (
    .clk      (clk),
    .rstn     (rstn),
    .hold_i   (hold),
    .wb_rd_i  (wb_rd),
    .wb_we_i  (wb_we),
    .wb_data_i(wb_data),
    .dx       (dx.dst),
    .xm       (xm.src)
  );

  mem_wb #(
    .DataAddrWidth(DataAddrWidth)
  ) u_mem_wb (
    .clk              (clk),
    .rstn             (rstn),
    .hold_i           (hold),
    .data_in_i        (data_in_i),
    .data_read_o      (data_read_o),
    .data_write_o     (data_write_o),
    .data_write_addr_o(data_write_addr_o),
    .data_out_o       (data_out_o),
    .wb_rd_o          (wb_rd),
    .wb_we_o          (wb_we),
    .wb_data_o        (wb_data),
    .xm               (xm.dst)
  );

  regfile u_regfile (
    .clk     (clk),
    .rstn    (rstn),
    .we_i    (wb_we),
    .waddr_i (wb_rd),
    .wdata_i (wb_data),
    .raddr1_i(rs1_addr),
    .raddr2_i(rs2_addr),
    .rdata1_o(rs1_data),
    .rdata2_o(rs2_data)
  );

endmodule

//--- include/tb_prog.svh
`ifndef TB_PROG_SVH
`define TB_PROG_SVH

localparam int ProgLen = 34;
localparam int NumStores = 12;

logic [31:0] rom[0:1023];
logic [11:0] exp_addr[NumStores];
logic [31:0] exp_data[NumStores];
string exp_name[NumStores];

// RV32I encoders
function automatic logic [31:0] rtype(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3, logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] itype(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                      logic [4:0] rd, logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] stype(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] btype(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] jtype(logic [20:0] imm, logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

task automatic set_store(int n, logic [11:0] addr, logic [31:0] data, string name);
  exp_addr[n] = addr;
  exp_data[n] = data;
  exp_name[n] = name;
endtask

task automatic load_program();
  // Unused words are NOPs
  for (int i = 0; i < 1024; i++) begin
    rom[i] = 32'h0000_0013;
  end
  rom[0] = itype(12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011);
  rom[1] = itype(12'hffd, 5'd1, 3'b000, 5'd2, 7'b0010011);
  rom[2] = rtype(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
  rom[3] = rtype(7'h20, 5'd1, 5'd2, 3'b000, 5'd4);
  rom[4] = rtype(7'h00, 5'd4, 5'd3, 3'b111, 5'd5);
  rom[5] = rtype(7'h00, 5'd2, 5'd5, 3'b110, 5'd6);
  rom[6] = rtype(7'h00, 5'd1, 5'd6, 3'b100, 5'd7);
  rom[7] = rtype(7'h00, 5'd1, 5'd4, 3'b010, 5'd8);
  rom[8] = {20'h12345, 5'd9, 7'b0110111};
  rom[9] = stype(12'h100, 5'd3, 5'd0);
  rom[10] = stype(12'h104, 5'd4, 5'd0);
  rom[11] = stype(12'h108, 5'd5, 5'd0);
  rom[12] = stype(12'h10c, 5'd6, 5'd0);
  rom[13] = stype(12'h110, 5'd7, 5'd0);
  rom[14] = stype(12'h114, 5'd8, 5'd0);
  rom[15] = stype(12'h118, 5'd9, 5'd0);
  // Write to x0 right before its read
  rom[16] = itype(12'd9, 5'd0, 3'b000, 5'd0, 7'b0010011);
  rom[17] = stype(12'h11c, 5'd0, 5'd0);
  // Load followed at once by its user
  rom[18] = itype(12'h040, 5'd0, 3'b010, 5'd10, 7'b0000011);
  rom[19] = rtype(7'h00, 5'd1, 5'd10, 3'b000, 5'd11);
  rom[20] = stype(12'h120, 5'd11, 5'd0);
  rom[21] = itype(12'h100, 5'd0, 3'b010, 5'd12, 7'b0000011);
  rom[22] = rtype(7'h00, 5'd12, 5'd12, 3'b000, 5'd13);
  rom[23] = stype(12'h124, 5'd13, 5'd0);
  // Taken branches skip the store behind them
  rom[24] = btype(13'd8, 5'd1, 5'd1, 3'b000);
  rom[25] = stype(12'h1f0, 5'd1, 5'd0);
  rom[26] = btype(13'd8, 5'd2, 5'd1, 3'b001);
  rom[27] = stype(12'h1f4, 5'd1, 5'd0);
  rom[28] = btype(13'd8, 5'd2, 5'd1, 3'b000);
  rom[29] = stype(12'h128, 5'd2, 5'd0);
  rom[30] = jtype(21'd8, 5'd14);
  rom[31] = stype(12'h1f8, 5'd1, 5'd0);
  rom[32] = stype(12'h12c, 5'd14, 5'd0);
  rom[33] = jtype(21'd0, 5'd0);

  set_store(0, 12'h100, 32'h0000_0007, "alu_add");
  set_store(1, 12'h104, 32'hffff_fffd, "alu_sub");
  set_store(2, 12'h108, 32'h0000_0005, "alu_and");
  set_store(3, 12'h10c, 32'h0000_0007, "alu_or");
  set_store(4, 12'h110, 32'h0000_0002, "alu_xor");
  set_store(5, 12'h114, 32'h0000_0001, "alu_slt");
  set_store(6, 12'h118, 32'h1234_5000, "lui");
  set_store(7, 12'h11c, 32'h0000_0000, "x0_write");
  set_store(8, 12'h120, 32'h1000_0045, "load_use");
  set_store(9, 12'h124, 32'h0000_000e, "load_after_store");
  set_store(10, 12'h128, 32'h0000_0002, "untaken_branch");
  set_store(11, 12'h12c, 32'h0000_007c, "jal_link");
endtask

`endif

//--- test/tb_cpu.sv
module tb_cpu;

  `include "tb_prog.svh"

  localparam int TimeoutCycles = 10 + ProgLen * 40 * 2;

  logic clk = 1'b0;
  logic rstn;
  logic [31:0] inst_in_i;
  logic inst_read_o;
  logic [11:0] inst_addr_o;
  logic [31:0] data_in_i;
  logic data_read_o;
  logic data_write_o;
  logic [11:0] data_write_addr_o;
  logic [31:0] data_out_o;
  logic stallreq_from_imem;
  logic stallreq_from_dmem;

  logic [31:0] dmem[256];
  logic [7:0] lfsr = 8'd85;
  logic stall_on = 1'b0;
  logic store_fire;
  int store_idx = 0;

  cpu UUT (
    .clk               (clk),
    .rstn              (rstn),
    .inst_in_i         (inst_in_i),
    .inst_read_o       (inst_read_o),
    .inst_addr_o       (inst_addr_o),
    .data_in_i         (data_in_i),
    .data_read_o       (data_read_o),
    .data_write_o      (data_write_o),
    .data_write_addr_o (data_write_addr_o),
    .data_out_o        (data_out_o),
    .stallreq_from_imem(stallreq_from_imem),
    .stallreq_from_dmem(stallreq_from_dmem)
  );

  always #2 clk = ~clk;

  task automatic stop_with_failure(string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
    stop_with_failure($sformatf("Mismatch %s expected %h actual %h", name, expected, actual));
  endtask

  // x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_step(logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  initial begin
    rstn = 1'b0;
    inst_in_i = '0;
    data_in_i = '0;
    stallreq_from_imem = 1'b0;
    stallreq_from_dmem = 1'b0;
    load_program();
    // Fill pattern is the byte address plus a base
    for (int i = 0; i < 256; i++) begin
      dmem[i] = 32'h1000_0000 + i * 4;
    end
    repeat (10) @(posedge clk);
    stall_on = 1'b1;
    #1;
    rstn = 1'b1;
  end

  // Two LFSR bits per memory, stall when both are set
  always @(posedge clk) begin
    #1;
    if (stall_on) begin
      lfsr = lfsr_step(lfsr);
      stallreq_from_imem = lfsr[0];
      lfsr = lfsr_step(lfsr);
      stallreq_from_imem = stallreq_from_imem & lfsr[0];
      lfsr = lfsr_step(lfsr);
      stallreq_from_dmem = lfsr[0];
      lfsr = lfsr_step(lfsr);
      stallreq_from_dmem = stallreq_from_dmem & lfsr[0];
    end
  end

  // Memories with one cycle registered read
  always @(posedge clk) begin
    if (inst_read_o) begin
      inst_in_i <= #1 rom[inst_addr_o[11:2]];
    end
    if (data_read_o) begin
      data_in_i <= #1 dmem[data_write_addr_o[9:2]];
    end
    if (store_fire) begin
      dmem[data_write_addr_o[9:2]] <= data_out_o;
      store_idx <= store_idx + 1;
    end
  end

  assign store_fire = rstn && data_write_o && !stallreq_from_imem && !stallreq_from_dmem;

  a_reset_quiet : assert property (@(posedge clk) !rstn |-> !data_read_o && !data_write_o)
  else stop_with_failure("Data strobe went high while reset was asserted");

  a_first_fetch : assert property (@(posedge clk) $rose(rstn) |-> inst_read_o && inst_addr_o == '0)
  else stop_with_failure("First instruction fetch after reset was not from address 0");

  a_store_count : assert property (@(posedge clk) store_fire |-> store_idx < NumStores)
  else stop_with_failure("Store seen after the last expected store");

  a_store_addr : assert property (@(posedge clk)
    store_fire && store_idx < NumStores |-> data_write_addr_o == exp_addr[store_idx])
  else report_mismatch($sformatf("%s address", exp_name[$sampled(store_idx)]),
                       32'(exp_addr[$sampled(store_idx)]), 32'($sampled(data_write_addr_o)));

  a_store_data : assert property (@(posedge clk)
    store_fire && store_idx < NumStores |-> data_out_o == exp_data[store_idx])
  else report_mismatch($sformatf("%s data", exp_name[$sampled(store_idx)]),
                       exp_data[$sampled(store_idx)], $sampled(data_out_o));

  // Extra cycles after the last store catch stores that should never appear
  initial begin
    wait (store_idx == NumStores);
    repeat (20) @(posedge clk);
    $display("STATUS: PASS");
    $finish;
  end

  initial begin
    #(TimeoutCycles * 4);
    stop_with_failure($sformatf("Timeout with %0d of %0d stores seen", store_idx, NumStores));
  end

endmodule

//--- src.f
+incdir+include
hw/cpu_pkg.sv
hw/cpu_ifs.sv
hw/fetch.sv
hw/decode.sv
hw/execute.sv
hw/mem_wb.sv
hw/regfile.sv
hw/cpu.sv
test/tb_cpu.sv

//--- Bender.yml
package:
  name: cpu

sources:
  - files:
      - hw/cpu_pkg.sv
      - hw/cpu_ifs.sv
      - hw/fetch.sv
      - hw/decode.sv
      - hw/execute.sv
      - hw/mem_wb.sv
      - hw/regfile.sv
      - hw/cpu.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_cpu.sv
